/* logic/axi_ls_pkg.sv */
package axi_ls_pkg;

    // RAM depth in 64-bit words, used as the default by top and RAM
    localparam int MEM_WORDS_DEF = 256;

    typedef logic [63:0] xlen_t;   // data word
    typedef logic [63:0] addr_t;   // byte address
    typedef logic [7:0]  strb_t;   // one enable per byte lane
    typedef logic [2:0]  size_t;   // AXI size code
    typedef logic [1:0]  resp_t;   // AXI response

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // 8 bytes per beat
    localparam size_t SIZE_DWORD = 3'd3;

    // requester command, data and mask still unshifted
    typedef struct packed {
        logic  wr;
        addr_t addr;
        xlen_t wdata;
        strb_t wmask;
        size_t size;
    } mem_req_t;

    typedef struct packed {
        xlen_t rdata;   // full aligned word
        resp_t resp;
    } mem_rsp_t;

    typedef struct packed {
        addr_t addr;
        size_t size;
    } axi_aw_t;

    typedef struct packed {
        xlen_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        resp_t resp;
    } axi_b_t;

    typedef struct packed {
        addr_t addr;
        size_t size;
    } axi_ar_t;

    typedef struct packed {
        xlen_t data;
        resp_t resp;
        logic  last;
    } axi_r_t;

endpackage

/* logic/axi_ls_master.sv */
`timescale 1ns/1ps

module axi_ls_master (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 req_valid_i,
    input  axi_ls_pkg::mem_req_t req_i,
    output logic                 req_ok_o,
    output axi_ls_pkg::mem_rsp_t rsp_o,
    output logic                 idle_o,

    output logic                 aw_valid_o,
    output axi_ls_pkg::axi_aw_t  aw_o,
    input  logic                 aw_ready_i,

    output logic                 w_valid_o,
    output axi_ls_pkg::axi_w_t   w_o,
    input  logic                 w_ready_i,

    output logic                 b_ready_o,
    input  logic                 b_valid_i,
    input  axi_ls_pkg::axi_b_t   b_i,

    output logic                 ar_valid_o,
    output axi_ls_pkg::axi_ar_t  ar_o,
    input  logic                 ar_ready_i,

    output logic                 r_ready_o,
    input  logic                 r_valid_i,
    input  axi_ls_pkg::axi_r_t   r_i
);
    import axi_ls_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_AW, W_DATA, W_RESP} w_state_e;
    typedef enum logic [1:0] {R_IDLE, R_AR, R_DATA, R_DONE} r_state_e;

    w_state_e w_state;
    w_state_e w_state_next;
    r_state_e r_state;
    r_state_e r_state_next;

    logic     done_q;     // response received, ok may be shown
    addr_t    addr_q;     // address of the running transaction
    mem_rsp_t rsp_q;
    logic     b_hs;
    logic     r_hs;
    logic     addr_hit;

    assign b_hs     = b_valid_i && b_ready_o;
    assign r_hs     = r_valid_i && r_ready_o;
    assign addr_hit = (req_i.addr == addr_q);

    // write sequence: AW, then W, then wait for B
    always_comb begin
        w_state_next = w_state;
        case (w_state)
            W_IDLE: begin
                if (req_valid_i && req_i.wr && r_state == R_IDLE) begin
                    w_state_next = W_AW;
                end
            end
            W_AW: begin
                if (aw_ready_i) begin
                    w_state_next = W_DATA;
                end
            end
            W_DATA: begin
                if (w_ready_i) begin
                    w_state_next = W_RESP;
                end
            end
            W_RESP: begin
                // stays here holding ok until valid drops or the address moves
                if (done_q) begin
                    if (!req_valid_i) begin
                        w_state_next = W_IDLE;
                    end else if (!addr_hit) begin
                        w_state_next = req_i.wr ? W_AW : W_IDLE;
                    end
                end
            end
            default: w_state_next = W_IDLE;
        endcase
    end

    // read sequence: AR, then R
    always_comb begin
        r_state_next = r_state;
        case (r_state)
            R_IDLE: begin
                if (req_valid_i && !req_i.wr && w_state == W_IDLE) begin
                    r_state_next = R_AR;
                end
            end
            R_AR: begin
                if (ar_ready_i) begin
                    r_state_next = R_DATA;
                end
            end
            R_DATA: begin
                if (r_valid_i) begin
                    r_state_next = R_DONE;
                end
            end
            R_DONE: begin
                if (!req_valid_i) begin
                    r_state_next = R_IDLE;
                end else if (!addr_hit) begin
                    r_state_next = req_i.wr ? R_IDLE : R_AR;   // write restarts from idle
                end
            end
            default: r_state_next = R_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state <= W_IDLE;
            r_state <= R_IDLE;
            done_q  <= 1'b0;
        end else begin
            w_state <= w_state_next;
            r_state <= r_state_next;
            if (b_hs || r_hs) begin
                done_q <= 1'b1;
            end else if (w_state_next != W_RESP && r_state_next != R_DONE) begin
                done_q <= 1'b0;
            end
        end
    end

    // address taken while the address phase is presented
    always_ff @(posedge clock) begin
        if (aw_valid_o || ar_valid_o) begin
            addr_q <= req_i.addr;
        end
        if (b_hs) begin
            rsp_q.rdata <= '0;            // writes carry no data back
            rsp_q.resp  <= b_i.resp;
        end else if (r_hs) begin
            rsp_q.rdata <= r_i.data;
            rsp_q.resp  <= r_i.resp;
        end
    end

    assign aw_valid_o = (w_state == W_AW);
    assign w_valid_o  = (w_state == W_DATA);
    assign b_ready_o  = (w_state == W_RESP) && !done_q;
    assign ar_valid_o = (r_state == R_AR);
    assign r_ready_o  = (r_state == R_DATA);

    assign aw_o.addr = {req_i.addr[63:3], 3'b000};    // word aligned
    assign aw_o.size = req_i.size;

    // move data and strobe into the lane of the addressed byte
    assign w_o.data = req_i.wdata << {req_i.addr[2:0], 3'b000};
    assign w_o.strb = req_i.wmask << req_i.addr[2:0];
    assign w_o.last = 1'b1;                           // single beat

    assign ar_o.addr = req_i.addr;
    assign ar_o.size = req_i.size;

    // ok only for the address that was actually served
    assign req_ok_o = done_q && addr_hit;
    assign rsp_o    = req_ok_o ? rsp_q : mem_rsp_t'('0);
    assign idle_o   = (w_state == W_IDLE) && (r_state == R_IDLE);

endmodule

/* logic/axi_ls_arbiter.sv */
`timescale 1ns/1ps

module axi_ls_arbiter (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 lsu_valid_i,
    input  axi_ls_pkg::mem_req_t lsu_req_i,
    output logic                 lsu_ok_o,
    output axi_ls_pkg::mem_rsp_t lsu_rsp_o,

    input  logic                 ifu_valid_i,
    input  axi_ls_pkg::addr_t    ifu_addr_i,
    output logic                 ifu_ok_o,
    output axi_ls_pkg::mem_rsp_t ifu_rsp_o,

    input  logic                 bridge_idle_i,
    input  logic                 req_ok_i,
    input  axi_ls_pkg::mem_rsp_t rsp_i,
    output logic                 req_valid_o,
    output axi_ls_pkg::mem_req_t req_o
);
    import axi_ls_pkg::*;

    typedef enum logic [1:0] {OWN_NONE, OWN_LSU, OWN_IFU} owner_e;

    owner_e   owner;
    owner_e   owner_next;
    mem_req_t ifu_req;

    // fetch is a plain doubleword read
    always_comb begin
        ifu_req       = '0;
        ifu_req.wr    = 1'b0;
        ifu_req.addr  = ifu_addr_i;
        ifu_req.wmask = '0;
        ifu_req.size  = SIZE_DWORD;
    end

    always_comb begin
        owner_next = owner;
        case (owner)
            OWN_NONE: begin
                if (bridge_idle_i) begin
                    if (lsu_valid_i) begin
                        owner_next = OWN_LSU;     // load/store wins
                    end else if (ifu_valid_i) begin
                        owner_next = OWN_IFU;
                    end
                end
            end
            OWN_LSU:  owner_next = lsu_valid_i ? OWN_LSU : OWN_NONE;
            OWN_IFU:  owner_next = ifu_valid_i ? OWN_IFU : OWN_NONE;
            default:  owner_next = OWN_NONE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            owner <= OWN_NONE;
        end else begin
            owner <= owner_next;
        end
    end

    // only the owner sees the bridge; the other port reads zero
    always_comb begin
        req_valid_o = 1'b0;
        req_o       = '0;
        lsu_ok_o    = 1'b0;
        lsu_rsp_o   = '0;
        ifu_ok_o    = 1'b0;
        ifu_rsp_o   = '0;
        case (owner)
            OWN_LSU: begin
                req_valid_o = lsu_valid_i;
                req_o       = lsu_req_i;
                lsu_ok_o    = req_ok_i;
                lsu_rsp_o   = rsp_i;
            end
            OWN_IFU: begin
                req_valid_o = ifu_valid_i;
                req_o       = ifu_req;
                ifu_ok_o    = req_ok_i;
                ifu_rsp_o   = rsp_i;
            end
            default: ;
        endcase
    end

endmodule

/* logic/axi_ls_ram.sv */
`timescale 1ns/1ps

module axi_ls_ram #(
    parameter int MEM_WORDS = axi_ls_pkg::MEM_WORDS_DEF
) (
    input  logic                clock,
    input  logic                reset,

    input  logic                aw_valid_i,
    input  axi_ls_pkg::axi_aw_t aw_i,
    output logic                aw_ready_o,

    input  logic                w_valid_i,
    input  axi_ls_pkg::axi_w_t  w_i,
    output logic                w_ready_o,

    output logic                b_valid_o,
    output axi_ls_pkg::axi_b_t  b_o,
    input  logic                b_ready_i,

    input  logic                ar_valid_i,
    input  axi_ls_pkg::axi_ar_t ar_i,
    output logic                ar_ready_o,

    output logic                r_valid_o,
    output axi_ls_pkg::axi_r_t  r_o,
    input  logic                r_ready_i
);
    import axi_ls_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {WS_IDLE, WS_DATA, WS_RESP} ws_e;
    typedef enum logic {RS_IDLE, RS_RESP} rs_e;

    xlen_t            mem [MEM_WORDS];
    ws_e              ws;
    rs_e              rs;
    addr_t            waddr_q;
    resp_t            bresp_q;
    xlen_t            rdata_q;
    resp_t            rresp_q;
    logic             w_hit;
    logic             r_hit;
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;

    // true when the word lies inside the array
    function automatic logic in_range(addr_t a);
        return a[63:3] < 61'(MEM_WORDS);
    endfunction

    assign w_hit = in_range(waddr_q);
    assign r_hit = in_range(ar_i.addr);
    assign widx  = waddr_q[IDX_W+2:3];
    assign ridx  = ar_i.addr[IDX_W+2:3];

    assign aw_ready_o = (ws == WS_IDLE);
    assign w_ready_o  = (ws == WS_DATA);
    assign b_valid_o  = (ws == WS_RESP);
    assign ar_ready_o = (rs == RS_IDLE);
    assign r_valid_o  = (rs == RS_RESP);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ws <= WS_IDLE;
            rs <= RS_IDLE;
        end else begin
            case (ws)
                WS_IDLE: if (aw_valid_i) ws <= WS_DATA;
                WS_DATA: if (w_valid_i)  ws <= WS_RESP;
                WS_RESP: if (b_ready_i)  ws <= WS_IDLE;   // hold bvalid until taken
                default: ws <= WS_IDLE;
            endcase
            case (rs)
                RS_IDLE: if (ar_valid_i) rs <= RS_RESP;
                RS_RESP: if (r_ready_i)  rs <= RS_IDLE;
                default: rs <= RS_IDLE;
            endcase
        end
    end

    // write path
    always_ff @(posedge clock) begin
        if (aw_valid_i && aw_ready_o) begin
            waddr_q <= aw_i.addr;
        end
        if (w_valid_i && w_ready_o) begin
            bresp_q <= w_hit ? RESP_OKAY : RESP_SLVERR;
            if (w_hit) begin
                // merge only the enabled byte lanes
                for (int i = 0; i < 8; i++) begin
                    if (w_i.strb[i]) begin
                        mem[widx][8*i +: 8] <= w_i.data[8*i +: 8];
                    end
                end
            end
        end
    end

    // read path, out of range reads zero
    always_ff @(posedge clock) begin
        if (ar_valid_i && ar_ready_o) begin
            rdata_q <= r_hit ? mem[ridx] : '0;
            rresp_q <= r_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign b_o.resp = bresp_q;
    assign r_o.data = rdata_q;
    assign r_o.resp = rresp_q;
    assign r_o.last = 1'b1;    // single beat

endmodule

/* logic/axi_ls_top.sv */
`timescale 1ns/1ps

module axi_ls_top #(
    parameter int MEM_WORDS = axi_ls_pkg::MEM_WORDS_DEF
) (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 lsu_valid_i,
    input  axi_ls_pkg::mem_req_t lsu_req_i,
    output logic                 lsu_ok_o,
    output axi_ls_pkg::mem_rsp_t lsu_rsp_o,

    input  logic                 ifu_valid_i,
    input  axi_ls_pkg::addr_t    ifu_addr_i,
    output logic                 ifu_ok_o,
    output axi_ls_pkg::mem_rsp_t ifu_rsp_o
);
    import axi_ls_pkg::*;

    // arbiter to bridge
    logic     req_valid;
    mem_req_t req;
    logic     req_ok;
    mem_rsp_t rsp;
    logic     bridge_idle;

    // bridge to RAM
    logic     aw_valid;
    logic     aw_ready;
    axi_aw_t  aw;
    logic     w_valid;
    logic     w_ready;
    axi_w_t   w;
    logic     b_valid;
    logic     b_ready;
    axi_b_t   b;
    logic     ar_valid;
    logic     ar_ready;
    axi_ar_t  ar;
    logic     r_valid;
    logic     r_ready;
    axi_r_t   r;

    axi_ls_arbiter u_arbiter (
        .clock         (clock),
        .reset         (reset),
        .lsu_valid_i   (lsu_valid_i),
        .lsu_req_i     (lsu_req_i),
        .lsu_ok_o      (lsu_ok_o),
        .lsu_rsp_o     (lsu_rsp_o),
        .ifu_valid_i   (ifu_valid_i),
        .ifu_addr_i    (ifu_addr_i),
        .ifu_ok_o      (ifu_ok_o),
        .ifu_rsp_o     (ifu_rsp_o),
        .bridge_idle_i (bridge_idle),
        .req_ok_i      (req_ok),
        .rsp_i         (rsp),
        .req_valid_o   (req_valid),
        .req_o         (req)
    );

    axi_ls_master u_master (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ok_o    (req_ok),
        .rsp_o       (rsp),
        .idle_o      (bridge_idle),
        .aw_valid_o  (aw_valid),
        .aw_o        (aw),
        .aw_ready_i  (aw_ready),
        .w_valid_o   (w_valid),
        .w_o         (w),
        .w_ready_i   (w_ready),
        .b_ready_o   (b_ready),
        .b_valid_i   (b_valid),
        .b_i         (b),
        .ar_valid_o  (ar_valid),
        .ar_o        (ar),
        .ar_ready_i  (ar_ready),
        .r_ready_o   (r_ready),
        .r_valid_i   (r_valid),
        .r_i         (r)
    );

    axi_ls_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clock      (clock),
        .reset      (reset),
        .aw_valid_i (aw_valid),
        .aw_i       (aw),
        .aw_ready_o (aw_ready),
        .w_valid_i  (w_valid),
        .w_i        (w),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_o        (b),
        .b_ready_i  (b_ready),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .r_ready_i  (r_ready)
    );

endmodule

/* sim/axi_ls_tb.sv */
`timescale 1ns/1ps

module axi_ls_tb;
    import axi_ls_pkg::*;

    localparam int    MEM_WORDS  = 256;
    localparam int    MEM_BYTES  = MEM_WORDS * 8;
    localparam int    N_RAND     = 20;
    localparam int    N_SUB      = 12;     // 8 byte and 4 halfword writes
    localparam int    N_TXN      = 2 * N_RAND + 1 + 3 * N_SUB + 3 + 2 + 2;
    localparam int    MAX_CYCLES = 40 * N_TXN + 200;
    localparam addr_t SUB_ADDR   = 64'd2000;   // word 250 lies outside the random set

    logic     clock;
    logic     reset;
    logic     lsu_valid;
    mem_req_t lsu_req;
    logic     lsu_ok;
    mem_rsp_t lsu_rsp;
    logic     ifu_valid;
    addr_t    ifu_addr;
    logic     ifu_ok;
    mem_rsp_t ifu_rsp;

    xlen_t    ref_mem [MEM_WORDS];   // expected RAM contents
    addr_t    addrs [N_RAND];
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;

    axi_ls_top #(.MEM_WORDS(MEM_WORDS)) DUT (
        .clock       (clock),
        .reset       (reset),
        .lsu_valid_i (lsu_valid),
        .lsu_req_i   (lsu_req),
        .lsu_ok_o    (lsu_ok),
        .lsu_rsp_o   (lsu_rsp),
        .ifu_valid_i (ifu_valid),
        .ifu_addr_i  (ifu_addr),
        .ifu_ok_o    (ifu_ok),
        .ifu_rsp_o   (ifu_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic void flag_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endfunction

    // a port without ok carries no data
    assert property (@(posedge clock) lsu_ok || lsu_rsp == '0)
        else flag_error("lsu response data present without ok");
    assert property (@(posedge clock) ifu_ok || ifu_rsp == '0)
        else flag_error("ifu response data present without ok");
    assert property (@(posedge clock) !(lsu_ok && ifu_ok))
        else flag_error("both ports show ok together");
    assert property (@(posedge clock) (!reset || $rose(reset)) |-> (!lsu_ok && !ifu_ok))
        else flag_error("ok high in reset or on the first cycle after it");

    function automatic resp_t expect_resp(input addr_t addr);
        return (addr < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
    endfunction

    function automatic xlen_t expect_word(input addr_t addr);
        return (addr < MEM_BYTES) ? ref_mem[addr >> 3] : '0;
    endfunction

    // bytes land in the lane picked by the low address bits
    function automatic void ref_write(input addr_t addr, input xlen_t data, input strb_t mask);
        xlen_t lane_data;
        strb_t lane_strb;
        lane_data = data << (8 * addr[2:0]);
        lane_strb = mask << addr[2:0];
        if (addr < MEM_BYTES) begin
            for (int i = 0; i < 8; i++) begin
                if (lane_strb[i]) begin
                    ref_mem[addr >> 3][8*i +: 8] = lane_data[8*i +: 8];
                end
            end
        end
    endfunction

    task automatic check_rsp(input string what, input addr_t addr, input mem_rsp_t got,
                             input xlen_t exp_data, input resp_t exp_resp);
        checks++;
        assert (got.rdata === exp_data && got.resp === exp_resp)
            else flag_error($sformatf("%s at %h: got %h resp %0d, expected %h resp %0d",
                what, addr, got.rdata, got.resp, exp_data, exp_resp));
    endtask

    task automatic lsu_access(input logic wr, input addr_t addr, input xlen_t data,
                              input strb_t mask, input size_t size, output mem_rsp_t rsp);
        @(posedge clock);
        #1;
        lsu_req.wr    = wr;
        lsu_req.addr  = addr;
        lsu_req.wdata = data;
        lsu_req.wmask = mask;
        lsu_req.size  = size;
        lsu_valid     = 1'b1;
        do begin
            @(negedge clock);
        end while (!lsu_ok);
        rsp = lsu_rsp;
        @(posedge clock);
        #1;
        lsu_valid = 1'b0;
    endtask

    task automatic lsu_write(input addr_t addr, input xlen_t data, input strb_t mask,
                             input size_t size);
        mem_rsp_t rsp;
        lsu_access(1'b1, addr, data, mask, size, rsp);
        check_rsp("store", addr, rsp, '0, expect_resp(addr));   // writes return no data
        ref_write(addr, data, mask);
    endtask

    task automatic lsu_read(input addr_t addr);
        mem_rsp_t rsp;
        lsu_access(1'b0, addr, '0, '0, SIZE_DWORD, rsp);
        check_rsp("load", addr, rsp, expect_word(addr), expect_resp(addr));
    endtask

    task automatic ifu_read(input addr_t addr);
        mem_rsp_t rsp;
        @(posedge clock);
        #1;
        ifu_addr  = addr;
        ifu_valid = 1'b1;
        do begin
            @(negedge clock);
        end while (!ifu_ok);
        rsp = ifu_rsp;
        @(posedge clock);
        #1;
        ifu_valid = 1'b0;
        check_rsp("fetch", addr, rsp, expect_word(addr), expect_resp(addr));
    endtask

    initial begin
        xlen_t    data;
        void'($urandom(79));
        reset     = 1'b0;
        lsu_valid = 1'b0;
        lsu_req   = '0;
        ifu_valid = 1'b0;
        ifu_addr  = '0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b1;
        @(negedge clock);
        checks++;
        assert (!lsu_ok && !ifu_ok && lsu_rsp == '0 && ifu_rsp == '0)
            else flag_error("outputs not quiet on the first cycle after reset");

        // full words at distinct random addresses
        for (int i = 0; i < N_RAND; i++) begin
            addrs[i] = addr_t'(i * 12 + $urandom_range(0, 11)) << 3;
            data = {$urandom, $urandom};
            lsu_write(addrs[i], data, 8'hff, SIZE_DWORD);
            lsu_read(addrs[i]);
        end

        // byte and halfword stores into one word
        lsu_write(SUB_ADDR, {$urandom, $urandom}, 8'hff, SIZE_DWORD);
        for (int off = 0; off < 8; off++) begin
            lsu_write(SUB_ADDR + addr_t'(off), {$urandom, $urandom}, 8'h01, 3'd0);
            lsu_read(SUB_ADDR + addr_t'(off));
            ifu_read(SUB_ADDR + addr_t'(off));
        end
        for (int off = 0; off < 8; off += 2) begin
            lsu_write(SUB_ADDR + addr_t'(off), {$urandom, $urandom}, 8'h03, 3'd1);
            lsu_read(SUB_ADDR + addr_t'(off));
            ifu_read(SUB_ADDR + addr_t'(off));
        end

        // out of range address that aliases onto addrs[0] without the range check
        lsu_write(addr_t'(MEM_BYTES) + addrs[0], {$urandom, $urandom}, 8'hff, SIZE_DWORD);
        lsu_read(addr_t'(MEM_BYTES) + addrs[0]);
        lsu_read(addrs[0]);

        // both requesters in the same cycle
        @(posedge clock);
        #1;
        lsu_req      = '0;
        lsu_req.addr = addrs[2];
        lsu_req.size = SIZE_DWORD;
        lsu_valid    = 1'b1;
        ifu_addr     = addrs[3];
        ifu_valid    = 1'b1;
        do begin
            @(negedge clock);
            checks++;
            assert (!ifu_ok) else flag_error("fetch completed before the load");
        end while (!lsu_ok);
        check_rsp("load", addrs[2], lsu_rsp, expect_word(addrs[2]), RESP_OKAY);
        @(posedge clock);
        #1;
        lsu_valid = 1'b0;
        do begin
            @(negedge clock);
        end while (!ifu_ok);
        check_rsp("fetch", addrs[3], ifu_rsp, expect_word(addrs[3]), RESP_OKAY);
        @(posedge clock);
        #1;
        ifu_valid = 1'b0;

        // ok held while the address stays and restarted by a new one
        @(posedge clock);
        #1;
        lsu_req.addr = addrs[4];
        lsu_valid    = 1'b1;
        do begin
            @(negedge clock);
        end while (!lsu_ok);
        check_rsp("load", addrs[4], lsu_rsp, expect_word(addrs[4]), RESP_OKAY);
        repeat (3) begin
            @(negedge clock);
            checks++;
            assert (lsu_ok && lsu_rsp.rdata === expect_word(addrs[4])
                    && lsu_rsp.resp === RESP_OKAY)
                else flag_error("ok or data changed while the address was held");
        end
        @(posedge clock);
        #1;
        lsu_req.addr = addrs[5];
        @(negedge clock);
        checks++;
        assert (!lsu_ok) else flag_error("ok stayed high after the address changed");
        do begin
            @(negedge clock);
        end while (!lsu_ok);
        check_rsp("restart", addrs[5], lsu_rsp, expect_word(addrs[5]), RESP_OKAY);
        @(posedge clock);
        #1;
        lsu_valid = 1'b0;

        repeat (2) @(posedge clock);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
logic/axi_ls_pkg.sv
logic/axi_ls_master.sv
logic/axi_ls_arbiter.sv
logic/axi_ls_ram.sv
logic/axi_ls_top.sv
sim/axi_ls_tb.sv
